/* Makefile */
TOOL     = verilator
TOP      = tbDecimatingFilter
FILELIST = tb.f
BUILD    = obj_dir
FLAGS    = --binary --timing -j 0 --top-module $(TOP) --Mdir $(BUILD)

SIM     = $(BUILD)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(BUILD)

/* hw/busPkg.sv */
// Bus request type for the control port
// Address word with register and FIR coefficient views
// Address space codes for the upper nibble
package busPkg;

    typedef struct packed {
        logic [12:0] addr;
        logic [31:0] din;
        logic [3:0]  byteWrite;
    } busReqT;

    typedef struct packed {
        logic [3:0] space;
        logic [6:0] unused;
        logic [1:0] regIndex;
    } regViewT;

    typedef struct packed {
        logic [3:0] space;
        logic [4:0] unused;
        logic [3:0] tapIndex;
    } firViewT;

    // Same 13 address bits decoded per space
    typedef union packed {
        regViewT regView;
        firViewT firView;
    } busAddrT;

    localparam logic [3:0] REG_SPACE = 4'h1;
    localparam logic [3:0] FIR_SPACE = 4'h2;

endpackage

/* hw/cicComp.sv */
// Three-tap CIC droop compensator
// Symmetric taps -1/8, 5/4, -1/8 with unity DC gain
module cicComp (
    input  logic          clk,
    input  logic          rst,
    input  dfPkg::streamT in,
    output dfPkg::streamT out
);
    import dfPkg::*;

    sampleT hist [2];
    wideT   acc;

    // Small constant products reduce to shifts and adds
    always_comb begin
        acc = (wideT'(in.data) + wideT'(hist[1])) * wideT'(COMP_TAPS[0])
            + wideT'(hist[0]) * wideT'(COMP_TAPS[1]);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out.en <= 1'b0;
        end else begin
            out.en <= in.en;
            if (in.en) begin
                hist[0]  <= in.data;
                hist[1]  <= hist[0];
                out.data <= saturate(roundShift(acc, COMP_FRAC));
            end
        end
    end

endmodule

/* hw/cicDecimator.sv */
// Multi-stage CIC decimator
// Integrators on every input strobe, combs at the decimated rate
// Programmable ratio and output gain shift with saturation
module cicDecimator #(
    parameter int CIC_STAGES = 3
) (
    input  logic          clk,
    input  logic          rst,
    input  dfPkg::streamT in,
    input  logic [14:0]   decimation,
    input  logic [5:0]    gainShift,
    output dfPkg::streamT out
);
    import dfPkg::*;

    // Bit growth of 15 bits per stage for the largest ratio
    localparam int ACC_W = $bits(sampleT) + CIC_STAGES * 15;

    typedef logic signed [ACC_W-1:0] accT;

    accT         integ [CIC_STAGES];
    accT         combDelay [CIC_STAGES];
    accT         combTap [CIC_STAGES];
    accT         scaled;
    logic [14:0] count;
    logic        lastStrobe;
    logic        combFire;

    assign lastStrobe = (count + 15'd1) >= decimation;

    // Comb differences from the last integrator
    always_comb begin
        combTap[0] = integ[CIC_STAGES - 1] - combDelay[0];
        for (int k = 1; k < CIC_STAGES; k++) begin
            combTap[k] = combTap[k - 1] - combDelay[k];
        end
        scaled = combTap[CIC_STAGES - 1] >>> gainShift;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < CIC_STAGES; k++) begin
                integ[k]     <= '0;
                combDelay[k] <= '0;
            end
            count    <= '0;
            combFire <= 1'b0;
            out.en   <= 1'b0;
        end else begin
            // Integrator wrap-around cancels in the combs
            if (in.en) begin
                integ[0] <= integ[0] + accT'(in.data);
                for (int k = 1; k < CIC_STAGES; k++) begin
                    integ[k] <= integ[k] + integ[k - 1];
                end
                count <= lastStrobe ? '0 : count + 15'd1;
            end
            combFire <= in.en && lastStrobe;
            out.en   <= combFire;
            if (combFire) begin
                combDelay[0] <= integ[CIC_STAGES - 1];
                for (int k = 1; k < CIC_STAGES; k++) begin
                    combDelay[k] <= combTap[k - 1];
                end
                out.data <= saturate(wideT'(scaled));
            end
        end
    end

endmodule

/* hw/coefFir.sv */
// Programmable FIR with bus-accessible coefficients
// Full multiply-accumulate per input strobe, rounded and saturated
// Coefficients are Q2.17 so that unity gain fits
module coefFir #(
    parameter int FIR_TAPS = 16
) (
    input  logic           clk,
    input  logic           rst,
    input  busPkg::busReqT bus,
    input  logic           firSel,
    input  dfPkg::streamT  in,
    output logic [31:0]    rdata,
    output dfPkg::streamT  out
);
    import busPkg::*;
    import dfPkg::*;

    localparam int COEF_W = $bits(sampleT) + 1;

    typedef logic signed [COEF_W-1:0] coefT;

    localparam coefT UNITY = coefT'(1 << SAMPLE_FRAC);

    coefT       coef [FIR_TAPS];
    sampleT     hist [FIR_TAPS - 1];
    busAddrT    addr;
    logic [3:0] tap;
    wideT       acc;

    assign addr  = bus.addr;
    assign tap   = addr.firView.tapIndex;
    // Sign-extended readback
    assign rdata = 32'(coef[tap]);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < FIR_TAPS; k++) begin
                coef[k] <= (k == 0) ? UNITY : '0;
            end
        end else if (firSel) begin
            if (bus.byteWrite[0]) begin
                coef[tap][7:0] <= bus.din[7:0];
            end
            if (bus.byteWrite[1]) begin
                coef[tap][15:8] <= bus.din[15:8];
            end
            if (bus.byteWrite[2]) begin
                coef[tap][COEF_W-1:16] <= bus.din[COEF_W-1:16];
            end
        end
    end

    // Tap 0 takes the incoming sample
    always_comb begin
        acc = wideT'(in.data) * wideT'(coef[0]);
        for (int k = 1; k < FIR_TAPS; k++) begin
            acc = acc + wideT'(hist[k - 1]) * wideT'(coef[k]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out.en <= 1'b0;
        end else begin
            out.en <= in.en;
            if (in.en) begin
                hist[0] <= in.data;
                for (int k = 1; k < FIR_TAPS - 1; k++) begin
                    hist[k] <= hist[k - 1];
                end
                out.data <= saturate(roundShift(acc, SAMPLE_FRAC));
            end
        end
    end

endmodule

/* hw/decimatingFilter.sv */
// Top level of the down-conversion decimator
// Address decode, read mux, stage bypass routing and output register
// Chain: halfband, CIC, compensator, halfband, FIR
module decimatingFilter #(
    parameter int CIC_STAGES = 3,
    parameter int FIR_TAPS   = 16
) (
    input  logic           clk,
    input  logic           rst,
    input  busPkg::busReqT bus,
    input  dfPkg::streamT  rx,
    output logic [31:0]    busDout,
    output dfPkg::streamT  dfOut
);
    import busPkg::*;
    import dfPkg::*;

    busAddrT     addr;
    logic        regSel;
    logic        firSel;
    logic [31:0] regDout;
    logic [31:0] firDout;
    dfConfigT    cfg;

    // Stage inputs and outputs
    streamT hb0In, hb0Out;
    streamT cicIn, cicOut, compOut;
    streamT hb1In, hb1Out;
    streamT firIn, firOut;

    // Nearest active source after each stage position
    streamT afterHb0, afterCic, afterHb1, afterFir;

    assign addr   = bus.addr;
    assign regSel = addr.regView.space == REG_SPACE;
    assign firSel = addr.firView.space == FIR_SPACE;

    always_comb begin
        if (regSel) begin
            busDout = regDout;
        end else if (firSel) begin
            busDout = firDout;
        end else begin
            busDout = '0;
        end
    end

    dfRegs regs (.clk(clk), .rst(rst), .bus(bus), .regSel(regSel), .rdata(regDout), .cfg(cfg));

    assign afterHb0 = cfg.bypassHb0 ? rx : hb0Out;
    assign afterCic = cfg.bypassCic ? afterHb0 : compOut;
    assign afterHb1 = cfg.bypassHb1 ? afterCic : hb1Out;
    assign afterFir = cfg.bypassFir ? afterHb1 : firOut;

    // A bypassed stage sees a quiet input, which saves power
    always_ff @(posedge clk) begin
        if (rst) begin
            hb0In <= '0;
            cicIn <= '0;
            hb1In <= '0;
            firIn <= '0;
            dfOut <= '0;
        end else begin
            hb0In <= cfg.bypassHb0 ? '0 : rx;
            cicIn <= cfg.bypassCic ? '0 : afterHb0;
            hb1In <= cfg.bypassHb1 ? '0 : afterCic;
            firIn <= cfg.bypassFir ? '0 : afterHb1;
            dfOut <= afterFir;
        end
    end

    halfbandDecimate hb0 (.clk(clk), .rst(rst), .in(hb0In), .out(hb0Out));

    cicDecimator #(
        .CIC_STAGES(CIC_STAGES)
    ) cic (
        .clk       (clk),
        .rst       (rst),
        .in        (cicIn),
        .decimation(cfg.cicDecimation),
        .gainShift (cfg.cicShift),
        .out       (cicOut)
    );

    cicComp comp (.clk(clk), .rst(rst), .in(cicOut), .out(compOut));

    halfbandDecimate hb1 (.clk(clk), .rst(rst), .in(hb1In), .out(hb1Out));

    coefFir #(
        .FIR_TAPS(FIR_TAPS)
    ) fir (
        .clk   (clk),
        .rst   (rst),
        .bus   (bus),
        .firSel(firSel),
        .in    (firIn),
        .rdata (firDout),
        .out   (firOut)
    );

endmodule

/* hw/dfPkg.sv */
// Sample, stream and configuration types of the decimator
// Fixed halfband and compensator coefficients
// Rounding and saturation helpers shared by the stages
package dfPkg;

    // Q1.17 sample
    typedef logic signed [17:0] sampleT;
    // Wide accumulator for products and sums
    typedef logic signed [63:0] wideT;

    typedef struct packed {
        logic   en;
        sampleT data;
    } streamT;

    typedef struct packed {
        logic        bypassHb0;
        logic        bypassCic;
        logic        bypassHb1;
        logic        bypassFir;
        logic [5:0]  cicShift;
        logic [14:0] cicDecimation;
    } dfConfigT;

    localparam int unsigned SAMPLE_FRAC = 17;
    localparam sampleT SAMPLE_MAX = 18'sh1ffff;
    // Most negative Q1.17 value
    localparam sampleT SAMPLE_MIN = 18'sh20000;

    // Outer, inner and center halfband taps; zero taps are left out
    // 2*outer + 2*inner + center = 2^17
    localparam sampleT HB_TAPS [3] = '{-18'sd4096, 18'sd36864, 18'sd65536};

    // Compensator taps in eighths: -1/8, 5/4, -1/8
    localparam int unsigned COMP_FRAC = 3;
    localparam logic signed [4:0] COMP_TAPS [3] = '{-5'sd1, 5'sd10, -5'sd1};

    function automatic wideT roundShift(input wideT v, input int unsigned sh);
        wideT half;
        half = wideT'(1) <<< (sh - 1);
        return (v + half) >>> sh;
    endfunction

    function automatic sampleT saturate(input wideT v);
        if (v > wideT'(SAMPLE_MAX)) begin
            return SAMPLE_MAX;
        end
        if (v < wideT'(SAMPLE_MIN)) begin
            return SAMPLE_MIN;
        end
        return sampleT'(v);
    endfunction

endpackage

/* hw/dfRegs.sv */
// Control registers of the decimator
// Byte-lane writes, combinational readback, configuration output
module dfRegs (
    input  logic            clk,
    input  logic            rst,
    input  busPkg::busReqT  bus,
    input  logic            regSel,
    output logic [31:0]     rdata,
    output dfPkg::dfConfigT cfg
);
    import busPkg::*;

    busAddrT addr;
    logic    wrBypass;
    logic    wrCic;

    assign addr     = bus.addr;
    assign wrBypass = regSel && (addr.regView.regIndex == 2'd0);
    assign wrCic    = regSel && (addr.regView.regIndex == 2'd1);

    always_ff @(posedge clk) begin
        if (rst) begin
            // Everything bypassed, D = 4, shift 6
            cfg.bypassHb0     <= 1'b1;
            cfg.bypassCic     <= 1'b1;
            cfg.bypassHb1     <= 1'b1;
            cfg.bypassFir     <= 1'b1;
            cfg.cicShift      <= 6'd6;
            cfg.cicDecimation <= 15'd4;
        end else begin
            if (wrBypass && bus.byteWrite[0]) begin
                {cfg.bypassFir, cfg.bypassHb1, cfg.bypassCic, cfg.bypassHb0} <= bus.din[3:0];
            end
            if (wrCic && bus.byteWrite[0]) begin
                cfg.cicShift <= bus.din[5:0];
            end
            if (wrCic && bus.byteWrite[2]) begin
                cfg.cicDecimation[7:0] <= bus.din[23:16];
            end
            if (wrCic && bus.byteWrite[3]) begin
                cfg.cicDecimation[14:8] <= bus.din[30:24];
            end
        end
    end

    // Unmapped indices read as zero
    always_comb begin
        rdata = '0;
        case (addr.regView.regIndex)
            2'd0: begin
                rdata[3:0] = {cfg.bypassFir, cfg.bypassHb1, cfg.bypassCic, cfg.bypassHb0};
            end
            2'd1: begin
                rdata[5:0]   = cfg.cicShift;
                rdata[30:16] = cfg.cicDecimation;
            end
            default: begin
                rdata = '0;
            end
        endcase
    end

endmodule

/* hw/halfbandDecimate.sv */
// Seven-tap halfband filter with decimation by two
// Symmetric sum over the fixed taps, rounded and saturated
module halfbandDecimate (
    input  logic          clk,
    input  logic          rst,
    input  dfPkg::streamT in,
    output dfPkg::streamT out
);
    import dfPkg::*;

    // Six stored samples plus the incoming one form the window
    sampleT hist [6];
    logic   keep;
    wideT   outerPair;
    wideT   innerPair;
    wideT   acc;

    // Window positions 1 and 5 hold zero taps
    always_comb begin
        outerPair = wideT'(in.data) + wideT'(hist[5]);
        innerPair = wideT'(hist[1]) + wideT'(hist[3]);
        acc = outerPair * wideT'(HB_TAPS[0])
            + innerPair * wideT'(HB_TAPS[1])
            + wideT'(hist[2]) * wideT'(HB_TAPS[2]);
    end

    always_ff @(posedge clk) begin
        if (in.en) begin
            hist[0] <= in.data;
            for (int k = 1; k < 6; k++) begin
                hist[k] <= hist[k - 1];
            end
        end
    end

    // Every second filtered sample goes out
    always_ff @(posedge clk) begin
        if (rst) begin
            keep   <= 1'b0;
            out.en <= 1'b0;
        end else begin
            out.en <= in.en && keep;
            if (in.en) begin
                keep <= ~keep;
            end
            if (in.en && keep) begin
                out.data <= saturate(roundShift(acc, SAMPLE_FRAC));
            end
        end
    end

endmodule

/* tb.f */
hw/busPkg.sv
hw/dfPkg.sv
hw/dfRegs.sv
hw/halfbandDecimate.sv
hw/cicDecimator.sv
hw/cicComp.sv
hw/coefFir.sv
hw/decimatingFilter.sv
tests/tbDecimatingFilter.sv

/* tests/tbDecimatingFilter.sv */
// Directed testbench for the decimating filter
// Register and coefficient access, bypass, CIC, halfband and chain tests
// Value checker, LFSR stimulus, clock, reset and watchdog
module tbDecimatingFilter;
    import busPkg::*;
    import dfPkg::*;

    localparam int PERIOD = 100;
    localparam int DRIVE_DELAY = 10;
    // Longest path through all stages is 11 clocks
    localparam int DRAIN_CLKS = 16;
    localparam int CLKS_PER_SAMPLE = 1;
    localparam int BYPASS_SAMPLES = 64;
    localparam int CIC_SAMPLES = 200 + 320 + 320;
    localparam int HB_SAMPLES = 128;
    localparam int CHAIN_SAMPLES = 512;
    // Reset, bus accesses and drain time
    localparam int MARGIN_CLKS = 1000;
    localparam int TIMEOUT_CLKS = (BYPASS_SAMPLES + CIC_SAMPLES + HB_SAMPLES + CHAIN_SAMPLES)
        * CLKS_PER_SAMPLE + MARGIN_CLKS;
    localparam longint SAT_MAX = 131071;
    localparam longint SAT_MIN = -131072;
    // FIR tap of 0.75 in Q2.17
    localparam longint CHAIN_COEF = 98304;

    logic        clk;
    logic        rst;
    busReqT      bus;
    streamT      rx;
    logic [31:0] busDout;
    streamT      dfOut;

    int          errors;
    int          checks;
    logic [15:0] lfsr;
    sampleT      outQ [$];

    decimatingFilter #(
        .CIC_STAGES(3),
        .FIR_TAPS  (16)
    ) UUT (
        .clk    (clk),
        .rst    (rst),
        .bus    (bus),
        .rx     (rx),
        .busDout(busDout),
        .dfOut  (dfOut)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_CLKS * PERIOD);
        $display("Watchdog expired before the tests finished (checks %0d, errors %0d)",
            checks, errors);
        $display("TB FAILED");
        $finish;
    end

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 stepped once per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic checkValue(input string name, input longint got, input longint expected,
                              input int tol);
        longint diff;
        checks++;
        diff = got - expected;
        if (diff < 0) begin
            diff = -diff;
        end
        if (diff > longint'(tol)) begin
            errors++;
            $display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, expected);
        end
    endtask

    function automatic logic [12:0] regAddr(input logic [1:0] idx);
        return {REG_SPACE, 7'd0, idx};
    endfunction

    function automatic logic [12:0] firAddr(input logic [3:0] tap);
        return {FIR_SPACE, 5'd0, tap};
    endfunction

    // Floor of x * D^3 / 2^S clamped to the sample range
    function automatic longint cicExpected(input longint x, input longint d, input int s);
        longint v;
        v = (x * d * d * d) >>> s;
        if (v > SAT_MAX) begin
            v = SAT_MAX;
        end
        if (v < SAT_MIN) begin
            v = SAT_MIN;
        end
        return v;
    endfunction

    task automatic waitDriveSlot();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic busWrite(input logic [12:0] addr, input logic [31:0] data,
                            input logic [3:0] strobes);
        waitDriveSlot();
        bus.addr = addr;
        bus.din = data;
        bus.byteWrite = strobes;
        waitDriveSlot();
        bus.byteWrite = 4'b0000;
    endtask

    task automatic busRead(input logic [12:0] addr, output logic [31:0] data);
        waitDriveSlot();
        bus.addr = addr;
        bus.byteWrite = 4'b0000;
        @(negedge clk);
        data = busDout;
    endtask

    // Bit order is fir, hb1, cic, hb0
    task automatic setBypass(input logic [3:0] bits);
        busWrite(regAddr(2'd0), {28'd0, bits}, 4'b0001);
    endtask

    task automatic setCic(input logic [14:0] d, input logic [5:0] s);
        busWrite(regAddr(2'd1), {1'b0, d, 10'd0, s}, 4'b1101);
    endtask

    // Constant input at one strobe per clock, then idle while the chain drains
    task automatic runConstant(input sampleT x, input int n);
        outQ.delete();
        for (int i = 0; i < n + DRAIN_CLKS; i++) begin
            waitDriveSlot();
            if (dfOut.en) begin
                outQ.push_back(dfOut.data);
            end
            rx.en = (i < n);
            rx.data = x;
        end
    endtask

    task automatic checkSettled(input string name, input int expCount, input int skip,
                                input longint expected, input int tol);
        checkValue({name, " output count"}, longint'(outQ.size()), longint'(expCount), 0);
        for (int i = skip; i < outQ.size(); i++) begin
            checkValue({name, " dfOut.data"}, longint'(outQ[i]), expected, tol);
        end
    endtask

    task automatic testRegisters();
        logic [31:0] expReg [2];
        logic [31:0] mask [2];
        logic [31:0] laneMask;
        logic [31:0] data;
        logic [31:0] got;
        logic [1:0]  lane;
        int          idx;
        expReg[0] = 32'h0000_000f;
        expReg[1] = 32'h0004_0006;
        mask[0] = 32'h0000_000f;
        mask[1] = 32'h7fff_003f;
        for (int i = 0; i < 2; i++) begin
            busRead(regAddr(2'(i)), got);
            checkValue("busDout reset reg", longint'(got), longint'(expReg[i]), 0);
        end
        repeat (12) begin
            idx = int'(randBits(1));
            lane = 2'(randBits(2));
            data = randBits(32);
            laneMask = 32'hff << (8 * lane);
            busWrite(regAddr(2'(idx)), data, 4'b0001 << lane);
            expReg[idx] = (expReg[idx] & ~laneMask) | (data & laneMask & mask[idx]);
            busRead(regAddr(2'(idx)), got);
            checkValue("busDout reg", longint'(got), longint'(expReg[idx]), 0);
        end
    endtask

    task automatic testCoefficients();
        logic signed [18:0] coefs [16];
        logic [31:0]        got;
        logic [31:0]        expWord;
        busRead(firAddr(4'd0), got);
        checkValue("busDout coef0 reset", longint'(got), longint'(32'h0002_0000), 0);
        busRead(firAddr(4'd9), got);
        checkValue("busDout coef9 reset", longint'(got), longint'(0), 0);
        for (int t = 0; t < 16; t++) begin
            coefs[t] = 19'(randBits(19));
            busWrite(firAddr(4'(t)), 32'(coefs[t]), 4'b0111);
        end
        for (int t = 0; t < 16; t++) begin
            busRead(firAddr(4'(t)), got);
            expWord = 32'(coefs[t]);
            checkValue("busDout coef", longint'(got), longint'(expWord), 0);
        end
        busRead({4'h0, 9'h0a5}, got);
        checkValue("busDout unmapped", longint'(got), longint'(0), 0);
        busRead({4'hf, 9'h003}, got);
        checkValue("busDout unmapped", longint'(got), longint'(0), 0);
    endtask

    task automatic testFullBypass();
        streamT prev;
        setBypass(4'b1111);
        prev = rx;
        for (int i = 0; i <= BYPASS_SAMPLES; i++) begin
            waitDriveSlot();
            checkValue("dfOut.en", longint'(dfOut.en), longint'(prev.en), 0);
            checkValue("dfOut.data", longint'(dfOut.data), longint'(prev.data), 0);
            rx.en = (randBits(1) != 32'd0) && (i < BYPASS_SAMPLES);
            rx.data = sampleT'(randBits(18));
            prev = rx;
        end
        rx.en = 1'b0;
    endtask

    task automatic cicCase(input sampleT x, input int d, input int s, input int n);
        setCic(15'(d), 6'(s));
        runConstant(x, n);
        // Three comb outputs and the compensator history settle first
        checkSettled("CIC", n / d, 6, cicExpected(longint'(x), longint'(d), s), 0);
    endtask

    task automatic testCicAlone();
        setBypass(4'b1101);
        cicCase(18'sd1000, 5, 4, 200);
        cicCase(-18'sd3000, 8, 6, 320);
        cicCase(18'sd20000, 16, 2, 320);
    endtask

    task automatic testHalfbands();
        setBypass(4'b1010);
        runConstant(-18'sd12345, HB_SAMPLES);
        checkSettled("halfbands", HB_SAMPLES / 4, 8, longint'(-12345), 1);
    endtask

    task automatic testFullChain();
        longint expected;
        for (int t = 0; t < 16; t++) begin
            busWrite(firAddr(4'(t)), (t == 0) ? 32'(CHAIN_COEF) : 32'd0, 4'b0111);
        end
        setCic(15'd4, 6'd6);
        setBypass(4'b0000);
        runConstant(18'sd40000, CHAIN_SAMPLES);
        expected = (cicExpected(longint'(40000), longint'(4), 6) * CHAIN_COEF) >>> 17;
        // One LSB of rounding per stage
        checkSettled("chain", CHAIN_SAMPLES / 16, 16, expected, 5);
    endtask

    initial begin
        errors = 0;
        checks = 0;
        lfsr = 16'd35285;
        rst = 1'b1;
        bus = '0;
        rx = '0;
        repeat (5) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;

        testRegisters();
        testCoefficients();
        testFullBypass();
        testCicAlone();
        testHalfbands();
        testFullChain();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
